// ==== verilog/rvIsaPkg.sv ====
package rvIsaPkg;

    // Base opcodes of the supported subset
    localparam logic [6:0] OpRType  = 7'b0110011;
    localparam logic [6:0] OpIType  = 7'b0010011;
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;

    localparam logic [2:0] F3AddSub = 3'b000; // Bit 30 picks sub on R-type
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtT;

    typedef struct packed {
        logic [6:0] immHi;   // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;   // imm[4:0]
        logic [6:0] opcode;
    } sFmtT;

    // Branch offset is scattered over the word, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmtT;

    typedef union packed {
        logic [31:0] raw;
        rFmtT        r;
        iFmtT        i;
        sFmtT        s;
        bFmtT        b;
    } rvInstT;

endpackage

// ==== verilog/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

    // Datapath word width
    localparam int XLen = 32;

    // Operations the ALU understands
    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,  // Also used for beq compare
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4   // Signed compare, result 0 or 1
    } aluOpT;

endpackage

// ==== verilog/ctrlIf.sv ====
`timescale 1ns/1ps

// Decoded control settings for one instruction
interface ctrlIf import cpuCtrlPkg::*; ();
    logic            regWrite;
    logic            aluSrc;    // 0 rs2, 1 immediate
    logic            memWrite;
    logic            memToReg;  // Load data to register
    logic            branch;
    aluOpT           aluOp;
    logic [XLen-1:0] imm;       // Already sign extended

    modport dec (
        output regWrite, aluSrc, memWrite, memToReg, branch, aluOp, imm
    );

    modport dp (
        input regWrite, aluSrc, memWrite, memToReg, branch, aluOp, imm
    );
endinterface

// ==== verilog/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit import cpuCtrlPkg::*; (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            branchTaken,
    input  logic [XLen-1:0] imm,
    output logic [XLen-1:0] pc
);

    logic [XLen-1:0] pcPlus4;
    logic [XLen-1:0] branchTarget;

    assign pcPlus4      = pc + XLen'(4);
    assign branchTarget = pc + imm;  // B immediate carries bit 0 already

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= branchTaken ? branchTarget : pcPlus4;
        end
    end

endmodule

// ==== verilog/instMem.sv ====
`timescale 1ns/1ps

module instMem
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
#(
    parameter int ImemWords = 256
) (
    input  logic                         CLK,
    input  logic                         progWe,
    input  logic [$clog2(ImemWords)-1:0] progAddr,
    input  logic [XLen-1:0]              progData,
    input  logic [XLen-1:0]              pc,
    output rvInstT                       inst
);

    localparam int AddrW = $clog2(ImemWords);

    logic [31:0] mem [ImemWords];

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    // Word index, upper pc bits dropped so fetch wraps
    assign inst = mem[pc[AddrW+1:2]];

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile import cpuCtrlPkg::*; (
    input  logic            CLK,
    input  logic            rstN,
    input  logic            we,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [XLen-1:0] wd,
    output logic [XLen-1:0] rd1,
    output logic [XLen-1:0] rd2
);

    // x0 has no storage
    logic [XLen-1:0] regs [1:31];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== verilog/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
(
    input  logic   rstN,
    input  rvInstT inst,
    ctrlIf.dec     ctrl
);

    logic [XLen-1:0] immI;
    logic [XLen-1:0] immS;
    logic [XLen-1:0] immB;

    // Shared funct3 mapping for R-type and addi
    function automatic aluOpT f3ToAluOp(input logic [2:0] f3, input logic isSub);
        aluOpT op;
        case (f3)
            F3AddSub: op = isSub ? AluSub : AluAdd;
            F3Slt:    op = AluSlt;
            F3Or:     op = AluOr;
            F3And:    op = AluAnd;
            default:  op = AluAdd;
        endcase
        return op;
    endfunction

    // Immediates from the three views of the same word
    assign immI = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign immS = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
    assign immB = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                   inst.b.imm10to5, inst.b.imm4to1, 1'b0};

    always_comb begin
        // Defaults make unknown opcodes a no-op
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = AluAdd;
        ctrl.imm      = '0;

        case (inst.r.opcode)
            OpRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = f3ToAluOp(inst.r.funct3, inst.r.funct7[5]); // Bit 30
            end
            OpIType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = f3ToAluOp(inst.i.funct3, 1'b0); // No subi
                ctrl.imm      = immI;
            end
            OpLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.imm      = immI;
            end
            OpStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immS;
            end
            OpBranch: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = AluSub;  // Equal when difference is zero
                ctrl.imm    = immB;
            end
            default: begin
            end
        endcase

        // No architectural writes while held in reset
        if (!rstN) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import cpuCtrlPkg::*; (
    input  logic [XLen-1:0] a,
    input  logic [XLen-1:0] b,
    input  aluOpT           op,
    output logic [XLen-1:0] result,
    output logic            zero
);

    always_comb begin
        case (op)
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluSlt:  result = {{(XLen-1){1'b0}}, $signed(a) < $signed(b)};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0); // Drives beq

endmodule

// ==== verilog/dataMem.sv ====
`timescale 1ns/1ps

module dataMem import cpuCtrlPkg::*; #(
    parameter int DmemWords = 256
) (
    input  logic            CLK,
    input  logic            we,
    input  logic [XLen-1:0] addr,
    input  logic [XLen-1:0] wd,
    output logic [XLen-1:0] rd
);

    localparam int AddrW = $clog2(DmemWords);

    logic [XLen-1:0] mem [DmemWords];

    // Byte address to word index, wraps past the end
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[addr[AddrW+1:2]] <= wd;
        end
    end

    assign rd = mem[addr[AddrW+1:2]];

endmodule

// ==== verilog/singleCpu.sv ====
`timescale 1ns/1ps

module singleCpu
    import rvIsaPkg::*;
    import cpuCtrlPkg::*;
#(
    parameter int MemWords = 256
) (
    input  logic                        CLK,
    input  logic                        rstN,
    input  logic                        progWe,
    input  logic [$clog2(MemWords)-1:0] progAddr,
    input  logic [XLen-1:0]             progData,
    output logic [XLen-1:0]             pc,
    output logic [31:0]                 inst,
    output logic                        wbEn,
    output logic [4:0]                  wbReg,
    output logic [XLen-1:0]             wbData,
    output logic                        memWe,
    output logic [XLen-1:0]             memAddr,
    output logic [XLen-1:0]             memWdata
);

    rvInstT          instWord;
    logic            loadWe;
    logic [XLen-1:0] rd1;
    logic [XLen-1:0] rd2;
    logic [XLen-1:0] aluB;
    logic [XLen-1:0] aluResult;
    logic            aluZero;
    logic [XLen-1:0] loadData;
    logic            branchTaken;

    ctrlIf ctrl ();

    // Program writes only land while the core is in reset
    assign loadWe = progWe & ~rstN;

    pcUnit uPc (
        .CLK        (CLK),
        .rstN       (rstN),
        .branchTaken(branchTaken),
        .imm        (ctrl.imm),
        .pc         (pc)
    );

    instMem #(.ImemWords(MemWords)) uImem (
        .CLK     (CLK),
        .progWe  (loadWe),
        .progAddr(progAddr),
        .progData(progData),
        .pc      (pc),
        .inst    (instWord)
    );

    instDecoder uDec (
        .rstN(rstN),
        .inst(instWord),
        .ctrl(ctrl)
    );

    regFile uRegs (
        .CLK (CLK),
        .rstN(rstN),
        .we  (ctrl.regWrite),
        .rs1 (instWord.r.rs1),
        .rs2 (instWord.r.rs2),
        .rd  (instWord.r.rd),
        .wd  (wbData),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    assign aluB = ctrl.aluSrc ? ctrl.imm : rd2;

    alu uAlu (
        .a     (rd1),
        .b     (aluB),
        .op    (ctrl.aluOp),
        .result(aluResult),
        .zero  (aluZero)
    );

    dataMem #(.DmemWords(MemWords)) uDmem (
        .CLK (CLK),
        .we  (ctrl.memWrite),
        .addr(aluResult),
        .wd  (rd2),
        .rd  (loadData)
    );

    assign branchTaken = ctrl.branch & aluZero;
    assign wbData      = ctrl.memToReg ? loadData : aluResult;

    // Trace outputs
    assign inst     = instWord.raw;
    assign wbEn     = ctrl.regWrite & (instWord.r.rd != 5'd0); // x0 writes hidden
    assign wbReg    = instWord.r.rd;
    assign memWe    = ctrl.memWrite;
    assign memAddr  = aluResult;
    assign memWdata = rd2;

endmodule

// ==== bench/singleCpu_checker.sv ====
`timescale 1ns/1ps

module singleCpu_checker import rvIsaPkg::*; (
    input logic        CLK,
    input logic        rstN,
    input logic [31:0] pc,
    input logic [31:0] inst,
    input logic        wbEn,
    input logic [4:0]  wbReg,
    input logic        memWe
);

    // No register or memory writes while held in reset
    quietInReset: assert property (@(posedge CLK) !rstN |-> !wbEn && !memWe)
        else $error("write-back or store strobe active during reset");

    noX0Trace: assert property (@(posedge CLK) wbEn |-> wbReg != 5'd0)
        else $error("write-back reported for register x0");

    storeStrobe: assert property (@(posedge CLK) rstN && inst[6:0] == OpStore |-> memWe)
        else $error("store instruction without memory write strobe");

    // Only branches may leave the sequential path
    pcStep: assert property (@(posedge CLK)
        rstN && inst[6:0] != OpBranch |=> pc == $past(pc) + 32'd4)
        else $error("pc did not advance by 4 after a non-branch instruction");

endmodule

bind singleCpu singleCpu_checker uChecker (
    .CLK  (CLK),
    .rstN (rstN),
    .pc   (pc),
    .inst (inst),
    .wbEn (wbEn),
    .wbReg(wbReg),
    .memWe(memWe)
);

// ==== bench/singleCpuTb.sv ====
`timescale 1ns/1ps

module singleCpuTb;

    localparam int MemWords      = 256;
    localparam int AddrW         = $clog2(MemWords);
    localparam int ResetCycles   = 8;
    localparam int TimeoutCycles = 50;
    localparam int SampleDelay   = 5; // Outputs settled, next rising edge still ahead

    logic             CLK;
    logic             rstN;
    logic             progWe;
    logic [AddrW-1:0] progAddr;
    logic [31:0]      progData;
    logic [31:0]      pc;
    logic [31:0]      inst;
    logic             wbEn;
    logic [4:0]       wbReg;
    logic [31:0]      wbData;
    logic             memWe;
    logic [31:0]      memAddr;
    logic [31:0]      memWdata;

    logic [31:0] prog[$];
    logic [31:0] lfsrState;
    string       testName;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          testErrorsAtStart;

    singleCpu #(.MemWords(MemWords)) DUT (
        .CLK     (CLK),
        .rstN    (rstN),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .pc      (pc),
        .inst    (inst),
        .wbEn    (wbEn),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .memWe   (memWe),
        .memAddr (memAddr),
        .memWdata(memWdata)
    );

    always #10 CLK = ~CLK;

    // Encoders following the RV32I base formats
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addiInst(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [31:0] imm);
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lwInst(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] swInst(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beqInst(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [31:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] sext12(input logic [31:0] v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic stepCycle;
        @(posedge CLK);
        @(negedge CLK);
        #SampleDelay;
    endtask

    task automatic checkValue(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %h, actual %h", testName, label, expected, actual);
            errorCount++;
        end
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrorsAtStart = errorCount;
        testCount++;
        prog.delete();
    endtask

    task automatic finishTest;
        $display("Test %s done, %0d errors", testName, errorCount - testErrorsAtStart);
    endtask

    // Hold reset, write the program, release at a falling edge
    task automatic loadProgram;
        int n;
        n = prog.size();
        @(negedge CLK);
        rstN = 1'b0;
        for (int i = 0; i < ResetCycles || i < n; i++) begin
            progWe = (i < n);
            progAddr = AddrW'(i);
            progData = (i < n) ? prog[i] : 32'd0;
            @(negedge CLK);
        end
        progWe = 1'b0;
        rstN = 1'b1;
        #SampleDelay;
    endtask

    task automatic expectWb(input logic [4:0] target, input logic [31:0] expected,
                            input string label);
        int cycles;
        cycles = 0;
        while (!(wbEn === 1'b1 && wbReg == target) && cycles < TimeoutCycles) begin
            stepCycle();
            cycles++;
        end
        if (wbEn === 1'b1 && wbReg == target) begin
            checkValue(label, expected, wbData);
            stepCycle();
        end else begin
            $display("Timeout in %s: no write-back to x%0d within %0d cycles",
                     testName, target, TimeoutCycles);
            errorCount++;
        end
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data,
                               input string label);
        int cycles;
        cycles = 0;
        while (memWe !== 1'b1 && cycles < TimeoutCycles) begin
            stepCycle();
            cycles++;
        end
        if (memWe === 1'b1) begin
            checkValue({label, " addr"}, addr, memAddr);
            checkValue({label, " data"}, data, memWdata);
            stepCycle();
        end else begin
            $display("Timeout in %s: no store seen within %0d cycles", testName, TimeoutCycles);
            errorCount++;
        end
    endtask

    task automatic testAluOps;
        logic [31:0] a;
        logic [31:0] b;
        beginTest("aluOps");
        repeat (3) begin
            a = sext12(randomBits(12));
            b = sext12(randomBits(12));
            prog.delete();
            prog.push_back(addiInst(1, 0, a));
            prog.push_back(addiInst(2, 0, b));
            prog.push_back(rType(7'h00, 3'b000, 3, 1, 2)); // add
            prog.push_back(rType(7'h20, 3'b000, 4, 1, 2)); // sub
            prog.push_back(rType(7'h00, 3'b111, 5, 1, 2)); // and
            prog.push_back(rType(7'h00, 3'b110, 6, 1, 2)); // or
            prog.push_back(rType(7'h00, 3'b010, 7, 1, 2)); // slt
            prog.push_back(rType(7'h00, 3'b010, 8, 2, 1)); // slt swapped
            prog.push_back(beqInst(0, 0, 0)); // Spin here
            loadProgram();
            expectWb(1, a, "x1");
            expectWb(2, b, "x2");
            expectWb(3, a + b, "add");
            expectWb(4, a - b, "sub");
            expectWb(5, a & b, "and");
            expectWb(6, a | b, "or");
            expectWb(7, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, "slt");
            expectWb(8, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0, "slt swapped");
        end
        finishTest();
    endtask

    task automatic testSignExt;
        beginTest("signExt");
        prog.push_back(addiInst(1, 0, -2048));
        prog.push_back(addiInst(2, 0, 2047));
        prog.push_back(addiInst(3, 1, -1));
        prog.push_back(addiInst(4, 2, 1));
        prog.push_back(addiInst(5, 2, -2048));
        prog.push_back(beqInst(0, 0, 0));
        loadProgram();
        expectWb(1, 32'hffff_f800, "-2048");
        expectWb(2, 32'h0000_07ff, "2047");
        expectWb(3, 32'hffff_f7ff, "-2048-1");
        expectWb(4, 32'h0000_0800, "2047+1");
        expectWb(5, 32'hffff_ffff, "2047-2048");
        finishTest();
    endtask

    task automatic testStoreLoad;
        logic [31:0] v1;
        logic [31:0] v2;
        beginTest("storeLoad");
        v1 = sext12(randomBits(12));
        v2 = sext12(randomBits(12));
        prog.push_back(addiInst(1, 0, 64)); // Base address
        prog.push_back(addiInst(2, 0, v1));
        prog.push_back(addiInst(4, 0, v2));
        prog.push_back(swInst(2, 1, 8));
        prog.push_back(swInst(4, 1, -4)); // Negative offset
        prog.push_back(lwInst(5, 1, 8));
        prog.push_back(lwInst(6, 1, -4));
        prog.push_back(beqInst(0, 0, 0));
        loadProgram();
        expectStore(32'h48, v1, "sw +8");
        expectStore(32'h3c, v2, "sw -4");
        expectWb(5, v1, "lw +8");
        expectWb(6, v2, "lw -4");
        finishTest();
    endtask

    task automatic testBranch;
        logic [31:0] pcTrace[$];
        beginTest("branch");
        prog.push_back(addiInst(1, 0, 5));
        prog.push_back(addiInst(2, 0, 5));
        prog.push_back(beqInst(1, 2, 8));   // Taken, skips the next word
        prog.push_back(addiInst(3, 0, 1));
        prog.push_back(addiInst(4, 0, 2));
        prog.push_back(beqInst(1, 3, 8));   // x3 still zero, falls through
        prog.push_back(addiInst(5, 0, 3));
        prog.push_back(beqInst(0, 0, 0));
        pcTrace = {32'd0, 32'd4, 32'd8, 32'd16, 32'd20, 32'd24, 32'd28, 32'd28};
        loadProgram();
        foreach (pcTrace[k]) begin
            checkValue($sformatf("pc step %0d", k), pcTrace[k], pc);
            checkValue($sformatf("inst step %0d", k), prog[pcTrace[k] >> 2], inst);
            stepCycle();
        end
        finishTest();
    endtask

    task automatic testX0;
        beginTest("x0");
        prog.push_back(addiInst(0, 0, 77));
        prog.push_back(addiInst(1, 0, 123));
        prog.push_back(rType(7'h00, 3'b000, 2, 0, 1));
        prog.push_back(rType(7'h00, 3'b000, 3, 1, 0));
        prog.push_back(rType(7'h00, 3'b000, 4, 0, 0));
        prog.push_back(beqInst(0, 0, 0));
        loadProgram();
        checkValue("wbEn on x0 write", 32'd0, 32'(wbEn));
        expectWb(1, 123, "x1");
        expectWb(2, 123, "x0+x1");
        expectWb(3, 123, "x1+x0");
        expectWb(4, 0, "x0+x0");
        finishTest();
    endtask

    task automatic testReset;
        beginTest("reset");
        prog.push_back(addiInst(1, 0, 10));
        prog.push_back(addiInst(1, 1, 1));
        prog.push_back(addiInst(2, 1, 5));
        prog.push_back(swInst(1, 0, 0)); // Reset lands on this store
        prog.push_back(beqInst(0, 0, 0));
        loadProgram();
        expectWb(1, 10, "first pass x1");
        expectWb(1, 11, "first pass x1+1");
        @(negedge CLK);
        rstN = 1'b0;
        #SampleDelay;
        checkValue("memWe in reset", 32'd0, 32'(memWe));
        stepCycle();
        checkValue("wbEn in reset", 32'd0, 32'(wbEn)); // addi at pc 0 held off
        repeat (ResetCycles - 2) stepCycle();
        checkValue("pc in reset", 32'd0, pc);
        @(negedge CLK);
        rstN = 1'b1;
        #SampleDelay;
        checkValue("pc after release", 32'd0, pc);
        expectWb(1, 10, "second pass x1");
        expectWb(1, 11, "second pass x1+1");
        expectWb(2, 16, "second pass x2");
        finishTest();
    endtask

    initial begin
        CLK = 1'b0;
        rstN = 1'b0;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        lfsrState = 32'ha3619340;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        testAluOps();
        testSignExt();
        testStoreLoad();
        testBranch();
        testX0();
        testReset();
        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== singleCpu.f ====
verilog/rvIsaPkg.sv
verilog/cpuCtrlPkg.sv
verilog/ctrlIf.sv
verilog/pcUnit.sv
verilog/instMem.sv
verilog/regFile.sv
verilog/instDecoder.sv
verilog/alu.sv
verilog/dataMem.sv
verilog/singleCpu.sv
bench/singleCpu_checker.sv
bench/singleCpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := singleCpuTb
FILELIST  := singleCpu.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir
LOG       := sim.log
FAILMSG   := RESULT: FAIL
PASSMSG   := RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
